/* mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Width of a data word and of every general purpose register.
`define MIPS_XLEN 32

// Register specifier width inside the instruction word.
`define MIPS_REG_ADDR_W 5

// Number of architectural registers, register zero included.
`define MIPS_NUM_REGS 32

// Instruction memory size in 32-bit words.
`define MIPS_IMEM_DEPTH 256

// The program counter counts words, so it only needs to span the
// instruction memory.
`define MIPS_PC_W $clog2(`MIPS_IMEM_DEPTH)

// Data memory addresses are word addresses, byte offset dropped.
`define MIPS_WORD_SHIFT 2

`endif

/* mips_pkg.sv */
`default_nettype none

`include "mips_cfg.svh"

package mips_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    // Execute operand source; memory wins over writeback in the hazard unit.
    typedef enum logic [1:0] {
        FWD_RF  = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } fwd_sel_e;

    typedef struct packed {
        opcode_e                      opcode;
        logic [`MIPS_REG_ADDR_W-1:0]  rs;
        logic [`MIPS_REG_ADDR_W-1:0]  rt;
        logic [`MIPS_REG_ADDR_W-1:0]  rd;
        logic [4:0]                   shamt;
        funct_e                       funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e                      opcode;
        logic [`MIPS_REG_ADDR_W-1:0]  rs;
        logic [`MIPS_REG_ADDR_W-1:0]  rt;
        logic [15:0]                  imm;
    } i_fmt_t;

    // One instruction word, seen either as R-type or as I-type.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef struct packed {
        logic    reg_write;
        logic    mem_to_reg;
        logic    mem_write;
        logic    branch;
        logic    alu_src_imm;
        logic    reg_dst_rd;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        instr_u                 instr;
        logic [`MIPS_PC_W-1:0]  pc_next;
    } if_id_t;

    typedef struct packed {
        ctrl_t                        ctrl;
        logic [`MIPS_XLEN-1:0]        rd1;
        logic [`MIPS_XLEN-1:0]        rd2;
        logic [`MIPS_XLEN-1:0]        imm;
        logic [`MIPS_REG_ADDR_W-1:0]  rs;
        logic [`MIPS_REG_ADDR_W-1:0]  rt;
        logic [`MIPS_REG_ADDR_W-1:0]  dst;
    } id_ex_t;

    typedef struct packed {
        logic                         reg_write;
        logic                         mem_to_reg;
        logic                         mem_write;
        logic [`MIPS_XLEN-1:0]        alu_result;
        logic [`MIPS_XLEN-1:0]        store_data;
        logic [`MIPS_REG_ADDR_W-1:0]  dst;
    } ex_mem_t;

    typedef struct packed {
        logic                         reg_write;
        logic                         mem_to_reg;
        logic [`MIPS_XLEN-1:0]        alu_result;
        logic [`MIPS_XLEN-1:0]        load_data;
        logic [`MIPS_REG_ADDR_W-1:0]  dst;
    } mem_wb_t;

    typedef struct packed {
        logic                   wr_en;
        logic                   rd_en;
        logic [`MIPS_XLEN-1:0]  addr;
        logic [`MIPS_XLEN-1:0]  wdata;
    } dmem_req_t;

endpackage

`default_nettype wire

/* hazard_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module hazard_unit (
    input  logic                         branch_id
    ,input  logic [`MIPS_REG_ADDR_W-1:0] rs_id
    ,input  logic [`MIPS_REG_ADDR_W-1:0] rt_id

    ,input  logic [`MIPS_REG_ADDR_W-1:0] rs_ex
    ,input  logic [`MIPS_REG_ADDR_W-1:0] rt_ex
    ,input  logic [`MIPS_REG_ADDR_W-1:0] dst_ex
    ,input  logic                        mem_to_reg_ex
    ,input  logic                        reg_write_ex

    ,input  logic [`MIPS_REG_ADDR_W-1:0] dst_mem
    ,input  logic                        mem_to_reg_mem
    ,input  logic                        reg_write_mem

    ,input  logic [`MIPS_REG_ADDR_W-1:0] dst_wb
    ,input  logic                        reg_write_wb

    ,output logic                        stall
    ,output logic                        forward_rd1
    ,output logic                        forward_rd2
    ,output mips_pkg::fwd_sel_e          forward_src_a
    ,output mips_pkg::fwd_sel_e          forward_src_b
);

    logic ex_hits_id;
    logic mem_hits_id;
    logic load_use_stall;
    logic branch_stall;

    // Decode reads a register that the instruction in execute or memory targets.
    assign ex_hits_id  = (dst_ex != '0) && (dst_ex == rs_id || dst_ex == rt_id);
    assign mem_hits_id = (dst_mem != '0) && (dst_mem == rs_id || dst_mem == rt_id);

    // A load in execute has no data yet, so its consumer waits one cycle.
    assign load_use_stall = mem_to_reg_ex && ex_hits_id;

    // The branch compare sits in decode; results still in execute, or
    // loads still in memory, cannot be forwarded to it in time.
    assign branch_stall = branch_id
                          && ((reg_write_ex && ex_hits_id)
                              || (mem_to_reg_mem && mem_hits_id));

    assign stall = load_use_stall || branch_stall;

    // Branch operands take the ALU result waiting in memory.
    assign forward_rd1 = (rs_id != '0) && (rs_id == dst_mem) && reg_write_mem;
    assign forward_rd2 = (rt_id != '0) && (rt_id == dst_mem) && reg_write_mem;

    always_comb begin
        if (rs_ex != '0 && rs_ex == dst_mem && reg_write_mem)
            forward_src_a = mips_pkg::FWD_MEM;
        else if (rs_ex != '0 && rs_ex == dst_wb && reg_write_wb)
            forward_src_a = mips_pkg::FWD_WB;
        else
            forward_src_a = mips_pkg::FWD_RF;
    end

    always_comb begin
        if (rt_ex != '0 && rt_ex == dst_mem && reg_write_mem)
            forward_src_b = mips_pkg::FWD_MEM;
        else if (rt_ex != '0 && rt_ex == dst_wb && reg_write_wb)
            forward_src_b = mips_pkg::FWD_WB;
        else
            forward_src_b = mips_pkg::FWD_RF;
    end

endmodule

`default_nettype wire

/* control_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module control_decoder (
    input  mips_pkg::instr_u instr,
    output mips_pkg::ctrl_t  ctrl
);

    always_comb begin
        // Anything not recognised below leaves every enable low.
        ctrl        = '0;
        ctrl.alu_op = mips_pkg::ALU_ADD;

        case (instr.r_fmt.opcode)
            mips_pkg::OP_RTYPE: begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst_rd = 1'b1;
                case (instr.r_fmt.funct)
                    mips_pkg::FN_ADD: ctrl.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB: ctrl.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: ctrl.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:  ctrl.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT: ctrl.alu_op = mips_pkg::ALU_SLT;
                    default: begin
                        ctrl.reg_write  = 1'b0;
                        ctrl.reg_dst_rd = 1'b0;
                    end
                endcase
            end

            mips_pkg::OP_ADDI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end

            mips_pkg::OP_LW: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end

            mips_pkg::OP_SW: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end

            // The comparison itself happens in decode, outside the ALU.
            mips_pkg::OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = mips_pkg::ALU_SUB;
            end

            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module register_file (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`MIPS_REG_ADDR_W-1:0]  rd_addr1,
    input  logic [`MIPS_REG_ADDR_W-1:0]  rd_addr2,
    output logic [`MIPS_XLEN-1:0]        rd_data1,
    output logic [`MIPS_XLEN-1:0]        rd_data2,
    input  logic                         wr_en,
    input  logic [`MIPS_REG_ADDR_W-1:0]  wr_addr,
    input  logic [`MIPS_XLEN-1:0]        wr_data
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];
    logic                  wr_live;

    // Register zero is never written, so it keeps the zero from reset.
    assign wr_live = wr_en && (wr_addr != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Writeback lands in the same cycle that decode reads it.
    assign rd_data1 = (wr_live && wr_addr == rd_addr1) ? wr_data : regs[rd_addr1];
    assign rd_data2 = (wr_live && wr_addr == rd_addr2) ? wr_data : regs[rd_addr2];

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module alu (
    input  mips_pkg::alu_op_e      op,
    input  logic [`MIPS_XLEN-1:0]  a,
    input  logic [`MIPS_XLEN-1:0]  b,
    output logic [`MIPS_XLEN-1:0]  result,
    output logic                   zero
);

    logic set_lt;

    // Two's complement comparison.
    assign set_lt = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            mips_pkg::ALU_ADD: result = a + b;
            mips_pkg::ALU_SUB: result = a - b;
            mips_pkg::ALU_AND: result = a & b;
            mips_pkg::ALU_OR:  result = a | b;
            mips_pkg::ALU_SLT: result = {{(`MIPS_XLEN-1){1'b0}}, set_lt};
            default:           result = '0;
        endcase
    end

    // Only needed if beq ever moves into execute.
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* mips_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module mips_core (
    input  logic                   clk,
    input  logic                   reset,
    output logic [`MIPS_PC_W-1:0]  imem_addr,
    input  mips_pkg::instr_u       imem_data,
    output mips_pkg::dmem_req_t    dmem_req,
    input  logic [`MIPS_XLEN-1:0]  dmem_rdata,
    output logic                   wb_valid,
    output logic [`MIPS_REG_ADDR_W-1:0] wb_addr,
    output logic [`MIPS_XLEN-1:0]  wb_data
);

    logic [`MIPS_PC_W-1:0]        pc;
    logic [`MIPS_PC_W-1:0]        pc_plus1;
    logic [`MIPS_PC_W-1:0]        branch_target;
    mips_pkg::if_id_t             if_id;
    mips_pkg::id_ex_t             id_ex;
    mips_pkg::ex_mem_t            ex_mem;
    mips_pkg::mem_wb_t            mem_wb;

    mips_pkg::ctrl_t              ctrl_id;
    logic [`MIPS_XLEN-1:0]        rf_rd1;
    logic [`MIPS_XLEN-1:0]        rf_rd2;
    logic [`MIPS_XLEN-1:0]        imm_id;
    logic [`MIPS_REG_ADDR_W-1:0]  dst_id;
    logic [`MIPS_XLEN-1:0]        cmp_a;
    logic [`MIPS_XLEN-1:0]        cmp_b;
    logic                         branch_taken;

    logic                         stall;
    logic                         forward_rd1;
    logic                         forward_rd2;
    mips_pkg::fwd_sel_e           forward_src_a;
    mips_pkg::fwd_sel_e           forward_src_b;

    logic [`MIPS_XLEN-1:0]        src_a;
    logic [`MIPS_XLEN-1:0]        src_b;
    logic [`MIPS_XLEN-1:0]        alu_b;
    logic [`MIPS_XLEN-1:0]        alu_result;

    // Fetch. The PC counts words and the delay slot is fetched regardless.
    assign pc_plus1  = pc + 1'b1;
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= '0;
        else if (!stall)
            pc <= branch_taken ? branch_target : pc_plus1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            if_id.instr <= '0;
        end else if (!stall) begin
            if_id.instr   <= imem_data;
            if_id.pc_next <= pc_plus1;
        end
    end

    // Decode.
    control_decoder i_control_decoder (
        .instr (if_id.instr),
        .ctrl  (ctrl_id)
    );

    register_file i_register_file (
        .clk      (clk),
        .reset    (reset),
        .rd_addr1 (if_id.instr.i_fmt.rs),
        .rd_addr2 (if_id.instr.i_fmt.rt),
        .rd_data1 (rf_rd1),
        .rd_data2 (rf_rd2),
        .wr_en    (wb_valid),
        .wr_addr  (wb_addr),
        .wr_data  (wb_data)
    );

    assign imm_id = {{(`MIPS_XLEN-16){if_id.instr.i_fmt.imm[15]}}, if_id.instr.i_fmt.imm};
    assign dst_id = ctrl_id.reg_dst_rd ? if_id.instr.r_fmt.rd : if_id.instr.i_fmt.rt;

    // The target is relative to the delay slot, as in MIPS.
    assign branch_target = if_id.pc_next + imm_id[`MIPS_PC_W-1:0];

    assign cmp_a = forward_rd1 ? ex_mem.alu_result : rf_rd1;
    assign cmp_b = forward_rd2 ? ex_mem.alu_result : rf_rd2;
    assign branch_taken = ctrl_id.branch && (cmp_a == cmp_b);

    hazard_unit i_hazard_unit (
        .branch_id      (ctrl_id.branch),
        .rs_id          (if_id.instr.i_fmt.rs),
        .rt_id          (if_id.instr.i_fmt.rt),
        .rs_ex          (id_ex.rs),
        .rt_ex          (id_ex.rt),
        .dst_ex         (id_ex.dst),
        .mem_to_reg_ex  (id_ex.ctrl.mem_to_reg),
        .reg_write_ex   (id_ex.ctrl.reg_write),
        .dst_mem        (ex_mem.dst),
        .mem_to_reg_mem (ex_mem.mem_to_reg),
        .reg_write_mem  (ex_mem.reg_write),
        .dst_wb         (mem_wb.dst),
        .reg_write_wb   (mem_wb.reg_write),
        .stall          (stall),
        .forward_rd1    (forward_rd1),
        .forward_rd2    (forward_rd2),
        .forward_src_a  (forward_src_a),
        .forward_src_b  (forward_src_b)
    );

    // A stall lets decode repeat while execute gets a bubble.
    always_ff @(posedge clk) begin
        if (reset || stall) begin
            id_ex.ctrl <= '0;
        end else begin
            id_ex.ctrl <= ctrl_id;
            id_ex.rd1  <= rf_rd1;
            id_ex.rd2  <= rf_rd2;
            id_ex.imm  <= imm_id;
            id_ex.rs   <= if_id.instr.i_fmt.rs;
            id_ex.rt   <= if_id.instr.i_fmt.rt;
            id_ex.dst  <= dst_id;
        end
    end

    // Execute.
    always_comb begin
        case (forward_src_a)
            mips_pkg::FWD_MEM: src_a = ex_mem.alu_result;
            mips_pkg::FWD_WB:  src_a = wb_data;
            default:           src_a = id_ex.rd1;
        endcase
        case (forward_src_b)
            mips_pkg::FWD_MEM: src_b = ex_mem.alu_result;
            mips_pkg::FWD_WB:  src_b = wb_data;
            default:           src_b = id_ex.rd2;
        endcase
    end

    assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : src_b;

    alu i_alu (
        .op     (id_ex.ctrl.alu_op),
        .a      (src_a),
        .b      (alu_b),
        .result (alu_result),
        .zero   ()
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.reg_write  <= 1'b0;
            ex_mem.mem_to_reg <= 1'b0;
            ex_mem.mem_write  <= 1'b0;
        end else begin
            ex_mem.reg_write  <= id_ex.ctrl.reg_write;
            ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
            ex_mem.mem_write  <= id_ex.ctrl.mem_write;
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= src_b;
            ex_mem.dst        <= id_ex.dst;
        end
    end

    // Memory. The byte address from the ALU becomes a word address.
    assign dmem_req.wr_en = ex_mem.mem_write;
    assign dmem_req.rd_en = ex_mem.mem_to_reg;
    assign dmem_req.addr  = ex_mem.alu_result >> `MIPS_WORD_SHIFT;
    assign dmem_req.wdata = ex_mem.store_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb.reg_write  <= 1'b0;
            mem_wb.mem_to_reg <= 1'b0;
        end else begin
            mem_wb.reg_write  <= ex_mem.reg_write;
            mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.load_data  <= dmem_rdata;
            mem_wb.dst        <= ex_mem.dst;
        end
    end

    // Writeback doubles as the observation port.
    assign wb_valid = mem_wb.reg_write && (mem_wb.dst != '0);
    assign wb_addr  = mem_wb.dst;
    assign wb_data  = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

`default_nettype wire

/* mips_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module mips_checker #(
    parameter int END_PC     = 200,
    parameter int DMEM_WORDS = 64
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         program_ready,
    input  logic [`MIPS_XLEN-1:0]        imem [`MIPS_IMEM_DEPTH],
    input  logic [`MIPS_XLEN-1:0]        dmem_init [DMEM_WORDS],
    input  logic                         wb_valid,
    input  logic [`MIPS_REG_ADDR_W-1:0]  wb_addr,
    input  logic [`MIPS_XLEN-1:0]        wb_data,
    input  mips_pkg::dmem_req_t          dmem_req,
    output logic                         done,
    output int                           wb_seen,
    output int                           wb_total,
    output int                           st_seen,
    output int                           st_total,
    output int                           mismatch_count,
    output int                           other_count
);

    localparam int PC_W    = `MIPS_PC_W;
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    // One expected retirement. For loads and stores addr is the word address,
    // for register writes it is the register number.
    typedef struct packed {
        logic [PC_W-1:0]        pc;
        logic [5:0]             opcode;
        logic [`MIPS_XLEN-1:0]  addr;
        logic [`MIPS_XLEN-1:0]  data;
    } expect_t;

    expect_t wb_queue [$];
    expect_t st_queue [$];
    expect_t ld_queue [$];
    logic    model_ready;
    logic    model_stuck;
    int      ld_seen;
    int      ld_total;

    assign done = model_ready && !model_stuck && wb_seen == wb_total
                  && st_seen == st_total && ld_seen == ld_total;

    function automatic string test_name(input logic [5:0] opcode);
        case (opcode)
            mips_pkg::OP_RTYPE: test_name = "alu_rtype";
            mips_pkg::OP_ADDI:  test_name = "alu_addi";
            mips_pkg::OP_LW:    test_name = "load";
            mips_pkg::OP_SW:    test_name = "store";
            default:            test_name = "unknown";
        endcase
    endfunction

    // Executes the program one instruction at a time. The pc/npc pair gives
    // the single delay slot after every branch.
    task automatic run_model();
        logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];
        logic [`MIPS_XLEN-1:0] mem [DMEM_WORDS];
        logic [`MIPS_XLEN-1:0] w;
        logic [`MIPS_XLEN-1:0] a;
        logic [`MIPS_XLEN-1:0] b;
        logic [`MIPS_XLEN-1:0] imm;
        logic [`MIPS_XLEN-1:0] val;
        logic [`MIPS_XLEN-1:0] word;
        logic [PC_W-1:0]       pc;
        logic [PC_W-1:0]       npc;
        logic [PC_W-1:0]       next;
        logic                  val_ok;
        int                    steps;
        for (int i = 0; i < `MIPS_NUM_REGS; i++)
            regs[i] = '0;
        for (int i = 0; i < DMEM_WORDS; i++)
            mem[i] = dmem_init[i];
        pc    = '0;
        npc   = PC_W'(1);
        steps = 0;
        while (int'(pc) != END_PC && steps < 4 * END_PC) begin
            w    = imem[pc];
            a    = regs[w[25:21]];
            b    = regs[w[20:16]];
            imm  = {{16{w[15]}}, w[15:0]};
            word = (a + imm) >> 2;
            next = npc + PC_W'(1);
            case (w[31:26])
                mips_pkg::OP_RTYPE: begin
                    val_ok = 1'b1;
                    case (w[5:0])
                        mips_pkg::FN_ADD: val = a + b;
                        mips_pkg::FN_SUB: val = a - b;
                        mips_pkg::FN_AND: val = a & b;
                        mips_pkg::FN_OR:  val = a | b;
                        mips_pkg::FN_SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: begin
                            val    = '0;
                            val_ok = 1'b0;
                        end
                    endcase
                    if (val_ok && w[15:11] != '0) begin
                        regs[w[15:11]] = val;
                        wb_queue.push_back({pc, w[31:26], 32'(w[15:11]), val});
                    end
                end
                mips_pkg::OP_ADDI, mips_pkg::OP_LW: begin
                    if (w[31:26] == mips_pkg::OP_LW) begin
                        val = mem[word[DMEM_AW-1:0]];
                        ld_queue.push_back({pc, w[31:26], word, val});
                    end else begin
                        val = a + imm;
                    end
                    if (w[20:16] != '0) begin
                        regs[w[20:16]] = val;
                        wb_queue.push_back({pc, w[31:26], 32'(w[20:16]), val});
                    end
                end
                mips_pkg::OP_SW: begin
                    mem[word[DMEM_AW-1:0]] = b;
                    st_queue.push_back({pc, w[31:26], word, b});
                end
                mips_pkg::OP_BEQ: begin
                    // The target counts from the delay slot.
                    if (a == b)
                        next = pc + PC_W'(1) + imm[PC_W-1:0];
                end
                default: ;
            endcase
            pc  = npc;
            npc = next;
            steps++;
        end
        if (int'(pc) != END_PC) begin
            $display("error: reference model did not reach the end of the program");
            model_stuck = 1'b1;
        end
        wb_total = wb_queue.size();
        st_total = st_queue.size();
        ld_total = ld_queue.size();
    endtask

    task automatic check_writeback();
        expect_t e;
        if (wb_addr == '0) begin
            $display("error: wb_valid raised for a write to register zero");
            other_count++;
        end else if (wb_queue.size() == 0) begin
            $display("error: register write to r%0d after the last expected write", wb_addr);
            other_count++;
        end else begin
            e = wb_queue.pop_front();
            wb_seen++;
            if (32'(wb_addr) != e.addr || wb_data !== e.data) begin
                $display("mismatch %s at pc %0d: expected r%0d = %h, actual r%0d = %h",
                         test_name(e.opcode), e.pc, e.addr, e.data, wb_addr, wb_data);
                mismatch_count++;
            end
        end
    endtask

    task automatic check_store();
        expect_t e;
        if (st_queue.size() == 0) begin
            $display("error: store to word %0d after the last expected store", dmem_req.addr);
            other_count++;
        end else begin
            e = st_queue.pop_front();
            st_seen++;
            if (dmem_req.addr !== e.addr || dmem_req.wdata !== e.data) begin
                $display("mismatch %s at pc %0d: expected [%0d] = %h, actual [%0d] = %h",
                         test_name(e.opcode), e.pc, e.addr, e.data,
                         dmem_req.addr, dmem_req.wdata);
                mismatch_count++;
            end
        end
    endtask

    task automatic check_load();
        expect_t e;
        if (ld_queue.size() == 0) begin
            $display("error: load from word %0d after the last expected load", dmem_req.addr);
            other_count++;
        end else begin
            e = ld_queue.pop_front();
            ld_seen++;
            if (dmem_req.addr !== e.addr) begin
                $display("mismatch %s at pc %0d: expected read of [%0d], actual read of [%0d]",
                         test_name(e.opcode), e.pc, e.addr, dmem_req.addr);
                mismatch_count++;
            end
        end
    endtask

    initial begin
        model_ready = 1'b0;
        model_stuck = 1'b0;
        wait (program_ready === 1'b1);
        run_model();
        model_ready = 1'b1;
    end

    // Outputs are sampled half a cycle after the edge, when they are settled.
    always @(negedge clk) begin
        if (reset) begin
            if (wb_valid !== 1'b0 || dmem_req.wr_en !== 1'b0 || dmem_req.rd_en !== 1'b0) begin
                $display("error: writeback or memory strobe active during reset");
                other_count++;
            end
        end else if (model_ready) begin
            if (wb_valid === 1'b1)
                check_writeback();
            if (dmem_req.wr_en === 1'b1)
                check_store();
            if (dmem_req.rd_en === 1'b1)
                check_load();
        end
    end

endmodule

`default_nettype wire

/* tb_mips_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module tb_mips_core;

    localparam int PROG_LEN       = 200;
    localparam int DMEM_WORDS     = 64;
    localparam int DMEM_AW        = $clog2(DMEM_WORDS);
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 3 + 100;
    localparam int DRAIN_CYCLES   = 20;

    logic                         clk;
    logic                         reset;
    logic                         program_ready;
    logic [`MIPS_PC_W-1:0]        imem_addr;
    mips_pkg::instr_u             imem_data;
    mips_pkg::dmem_req_t          dmem_req;
    logic [`MIPS_XLEN-1:0]        dmem_rdata;
    logic                         wb_valid;
    logic [`MIPS_REG_ADDR_W-1:0]  wb_addr;
    logic [`MIPS_XLEN-1:0]        wb_data;

    logic [`MIPS_XLEN-1:0]        imem [`MIPS_IMEM_DEPTH];
    logic [`MIPS_XLEN-1:0]        dmem [DMEM_WORDS];
    logic [`MIPS_XLEN-1:0]        dmem_init [DMEM_WORDS];

    logic                         done;
    int                           wb_seen;
    int                           wb_total;
    int                           st_seen;
    int                           st_total;
    int                           mismatch_count;
    int                           other_count;
    int                           cycle_count;
    integer                       seed;

    mips_core i_mips_core (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

    mips_checker #(
        .END_PC     (PROG_LEN),
        .DMEM_WORDS (DMEM_WORDS)
    ) i_checker (
        .clk            (clk),
        .reset          (reset),
        .program_ready  (program_ready),
        .imem           (imem),
        .dmem_init      (dmem_init),
        .wb_valid       (wb_valid),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data),
        .dmem_req       (dmem_req),
        .done           (done),
        .wb_seen        (wb_seen),
        .wb_total       (wb_total),
        .st_seen        (st_seen),
        .st_total       (st_total),
        .mismatch_count (mismatch_count),
        .other_count    (other_count)
    );

    // Both memories answer in the same cycle.
    assign imem_data  = imem[imem_addr];
    assign dmem_rdata = dmem[dmem_req.addr[DMEM_AW-1:0]];

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DMEM_WORDS; i++)
                dmem[i] <= dmem_init[i];
        end else if (dmem_req.wr_en) begin
            dmem[dmem_req.addr[DMEM_AW-1:0]] <= dmem_req.wdata;
        end
    end

    function automatic int pick(input int n);
        logic [31:0] r;
        r = $random(seed);
        pick = int'(r % 32'(n));
    endfunction

    // Mostly r1 to r6, so that neighbouring instructions collide often.
    function automatic logic [4:0] pick_reg();
        int k;
        k = pick(16);
        if (k == 0)
            pick_reg = 5'd0;
        else if (k < 13)
            pick_reg = 5'(1 + k % 6);
        else
            pick_reg = 5'(pick(32));
    endfunction

    // Byte offset from register zero, word aligned.
    function automatic logic [15:0] word_offset();
        int k;
        k = (pick(4) == 0) ? pick(DMEM_WORDS) : pick(16);
        word_offset = 16'(4 * k);
    endfunction

    function automatic logic [31:0] encode_rtype(input logic [5:0] funct,
                                                 input logic [4:0] rd,
                                                 input logic [4:0] rs,
                                                 input logic [4:0] rt);
        encode_rtype = {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encode_itype(input logic [5:0]  op,
                                                 input logic [4:0]  rs,
                                                 input logic [4:0]  rt,
                                                 input logic [15:0] imm);
        encode_itype = {op, rs, rt, imm};
    endfunction

    task automatic build_program();
        int         kind;
        int         off;
        logic [4:0] rd;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [5:0] funct;
        for (int i = 0; i < `MIPS_IMEM_DEPTH; i++)
            imem[i] = '0;
        for (int i = 0; i < PROG_LEN; i++) begin
            kind = pick(20);
            rd   = pick_reg();
            rs   = pick_reg();
            rt   = pick_reg();
            if (kind < 8) begin
                case (pick(5))
                    0:       funct = mips_pkg::FN_ADD;
                    1:       funct = mips_pkg::FN_SUB;
                    2:       funct = mips_pkg::FN_AND;
                    3:       funct = mips_pkg::FN_OR;
                    default: funct = mips_pkg::FN_SLT;
                endcase
                imem[i] = encode_rtype(funct, rd, rs, rt);
            end else if (kind < 12) begin
                imem[i] = encode_itype(mips_pkg::OP_ADDI, rs, rt, 16'(pick(64)) - 16'd32);
            end else if (kind < 15) begin
                imem[i] = encode_itype(mips_pkg::OP_LW, 5'd0, rt, word_offset());
            end else if (kind < 18) begin
                imem[i] = encode_itype(mips_pkg::OP_SW, 5'd0, rt, word_offset());
            end else begin
                if (pick(4) == 0)
                    rt = rs;
                // Forward targets only, never past the closing loop.
                off = pick(8);
                if (i + 1 + off > PROG_LEN)
                    off = PROG_LEN - (i + 1);
                imem[i] = encode_itype(mips_pkg::OP_BEQ, rs, rt, 16'(off));
            end
        end
        // The program parks in a branch to itself with a nop delay slot.
        imem[PROG_LEN] = encode_itype(mips_pkg::OP_BEQ, 5'd0, 5'd0, 16'hffff);
    endtask

    task automatic finish_run(input logic timed_out);
        $display("errors: %0d mismatches, %0d other; writes %0d of %0d, stores %0d of %0d",
                 mismatch_count, other_count, wb_seen, wb_total, st_seen, st_total);
        if (!timed_out && mismatch_count == 0 && other_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        seed          = 80934;
        reset         = 1'b1;
        program_ready = 1'b0;
        build_program();
        for (int i = 0; i < DMEM_WORDS; i++)
            dmem_init[i] = 32'hd00d_0000 ^ (32'(i) * 32'h0001_0101);
        program_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        wait (done === 1'b1);
        // A few more cycles catch any retirement beyond the program's end.
        repeat (DRAIN_CYCLES) @(posedge clk);
        finish_run(1'b0);
    end

    always @(posedge clk) begin
        if (!reset) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("error: timeout after %0d cycles without all retirements", cycle_count);
                finish_run(1'b1);
            end
        end
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
mips_pkg.sv
hazard_unit.sv
control_decoder.sv
register_file.sv
alu.sv
mips_core.sv
mips_checker.sv
tb_mips_core.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_mips_core -f project.f -o sim_tb_mips_core
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/sim_tb_mips_core)
sim_status=$?
echo "$sim_output"
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Done: no errors" <<< "$sim_output"; then
    exit 0
fi
exit 1
